//--- Bender.yml
package:
  name: iobus

sources:
  - source/iobus_pkg.sv
  - source/msg_rx.sv
  - source/msg_tx.sv
  - source/iobus_ctl.sv
  - source/iobus.sv
  - target: test
    files:
      - tests/iobus_properties.sv
      - tests/iobus_tb.sv

//--- iobus.f
source/iobus_pkg.sv
source/msg_rx.sv
source/msg_tx.sv
source/iobus_ctl.sv
source/iobus.sv
tests/iobus_properties.sv
tests/iobus_tb.sv

//--- source/iobus.sv
`timescale 1ns/1ns
`default_nettype none

module iobus import iobus_pkg::*; (
	input  wire   clk_sys,
	input  wire   cl_reset,
	// link
	input  wire   byte_t rx_byte,
	input  wire   rx_strobe,
	input  wire   link_busy,
	output byte_t tx_byte,
	output logic  tx_strobe,
	// bus inputs
	input  wire   rs, rf, rok, rpe, rcl, rqb, rpn,
	input  wire   nb_t rnb,
	input  wire   word_t rad,
	input  wire   word_t rdt,
	input  wire   zw,
	// bus outputs
	output logic  zg,
	output logic  dpa, dw, dr, din, dok, den, dpe, dpn,
	output nb_t   dnb,
	output word_t dad,
	output word_t ddt
);

	rbus_t rbus;
	dbus_t dbus;
	msg_t  rx_msg;
	msg_t  tx_msg;
	logic  msg_ready;
	logic  tx_send;
	logic  tx_busy;

	assign rbus = '{rs: rs, rf: rf, rok: rok, rpe: rpe, rcl: rcl, rqb: rqb, rpn: rpn,
		rnb: rnb, rad: rad, rdt: rdt};

	assign {dpa, dw, dr, din, dok, den, dpe, dpn} = {dbus.dpa, dbus.dw, dbus.dr,
		dbus.din, dbus.dok, dbus.den, dbus.dpe, dbus.dpn};
	assign dnb = dbus.dnb;
	assign dad = dbus.dad;
	assign ddt = dbus.ddt;

	msg_rx u_rx (
		.clk_sys(clk_sys), .cl_reset(cl_reset),
		.rx_byte(rx_byte), .rx_strobe(rx_strobe),
		.rx_msg(rx_msg), .msg_ready(msg_ready)
	);

	msg_tx u_tx (
		.clk_sys(clk_sys), .cl_reset(cl_reset),
		.tx_send(tx_send), .tx_msg(tx_msg), .link_busy(link_busy),
		.tx_byte(tx_byte), .tx_strobe(tx_strobe), .tx_busy(tx_busy)
	);

	iobus_ctl u_ctl (
		.clk_sys(clk_sys), .cl_reset(cl_reset),
		.rbus(rbus), .zw(zw),
		.rx_msg(rx_msg), .msg_ready(msg_ready), .tx_busy(tx_busy),
		.dbus(dbus), .zg(zg), .tx_send(tx_send), .tx_msg(tx_msg)
	);

endmodule

`default_nettype wire

//--- source/iobus_ctl.sv
`timescale 1ns/1ns
`default_nettype none

module iobus_ctl import iobus_pkg::*; (
	input  wire   clk_sys,
	input  wire   cl_reset,
	input  wire   rbus_t rbus,
	input  wire   zw,
	input  wire   msg_t rx_msg,
	input  wire   msg_ready,
	input  wire   tx_busy,
	output dbus_t dbus,
	output logic  zg,
	output logic  tx_send,
	output msg_t  tx_msg
);

	ctl_state_t state;
	logic       cl_hold;	// latched bus clear
	logic       drv_en;	// d lines follow rx_msg

	logic       rx_req;
	code_t      rx_code;
	logic       rx_valid;
	logic       rx_pa;
	logic       d_req;	// valid request from the far side
	logic       d_resp;	// valid response from the far side
	logic       r_req;	// internal request for the far side
	logic       r_resp;	// internal reply to a far request
	logic       tx_idle;
	logic       send_go;
	msg_hdr_t   send_hdr;

	assign rx_req  = rx_msg.hdr.req;
	assign rx_code = rx_msg.hdr.code;
	assign rx_pa   = (rx_code == CMD_PA);

	// request and response codes share values, req bit picks the table
	always_comb begin
		if (rx_req) begin
			rx_valid = rx_code inside {CMD_PA, CMD_W, CMD_R, CMD_IN};
		end else begin
			rx_valid = rx_code inside {CMD_EN, CMD_OK, CMD_PE};
		end
	end

	assign d_req  = msg_ready && rx_valid && rx_req;
	assign d_resp = msg_ready && rx_valid && !rx_req;
	assign r_req  = (rbus.rs || rbus.rf) && !rbus.rad[15];	// bit 15 set stays local
	assign r_resp = rbus.rok || rbus.rpe;

	// tx_busy only rises the edge after tx_send
	assign tx_idle = !tx_busy && !tx_send;

	// command encoder, decides what goes out and when
	always_comb begin
		send_go  = 1'b0;
		send_hdr = '{req: 1'b1, code: CMD_S, spare: 3'b000};
		case (state)
			IDLE: begin
				if (cl_hold) begin	// clear wins over a request
					send_go       = 1'b1;
					send_hdr.code = CMD_CL;
				end else if (r_req) begin
					send_go       = 1'b1;
					send_hdr.code = rbus.rf ? CMD_F : CMD_S;
				end
			end
			R_RESP: begin
				if (r_resp) begin
					send_go       = 1'b1;
					send_hdr.req  = 1'b0;
					send_hdr.code = rbus.rok ? CMD_OK : CMD_PE;
				end
			end
			default: begin
				send_go = 1'b0;
			end
		endcase
	end

	// every outgoing message carries the current bus fields
	always_ff @(posedge clk_sys) begin
		if (send_go) begin
			tx_msg.hdr      <= send_hdr;
			tx_msg.a1.spare <= 2'b00;
			tx_msg.a1.qb    <= rbus.rqb;
			tx_msg.a1.pn    <= rbus.rpn;
			tx_msg.a1.nb    <= rbus.rnb;
			tx_msg.a2       <= rbus.rad;
			tx_msg.a3       <= rbus.rdt;
		end
	end

	always_ff @(posedge clk_sys or posedge cl_reset) begin
		if (cl_reset) begin
			state   <= IDLE;
			zg      <= 1'b0;
			drv_en  <= 1'b0;
			tx_send <= 1'b0;
			cl_hold <= 1'b0;
		end else begin
			tx_send <= send_go;	// one cycle pulse
			case (state)
				IDLE: begin
					if (cl_hold) begin
						state <= CLEAR;
					end else if (r_req) begin
						state <= R_REQ;
					end else if (d_req) begin
						if (rx_pa) begin	// no grant, no reply
							drv_en <= 1'b1;
							state  <= WAIT;
						end else begin
							zg    <= 1'b1;
							state <= D_REQ;
						end
					end
				end
				R_REQ: begin
					if (d_resp) begin
						drv_en <= 1'b1;
						state  <= D_RESP;
					end else if (d_req && !zw) begin	// collision
						state <= D_EN;
					end
				end
				D_RESP: begin
					if (!r_req) begin
						drv_en <= 1'b0;
						state  <= IDLE;
					end
				end
				D_EN: begin
					if (!r_req) begin	// now serve the far request
						if (rx_pa) begin
							drv_en <= 1'b1;
							state  <= WAIT;
						end else begin
							zg    <= 1'b1;
							state <= D_REQ;
						end
					end
				end
				D_REQ: begin
					if (zw) begin
						drv_en <= 1'b1;
						state  <= R_RESP;
					end
				end
				R_RESP: begin
					if (r_resp) begin
						state <= WAIT;
					end
				end
				CLEAR: begin
					if (!rbus.rcl && tx_idle) begin
						cl_hold <= 1'b0;
						state   <= IDLE;
					end
				end
				WAIT: begin
					if (tx_idle) begin	// reply fully out
						zg     <= 1'b0;
						drv_en <= 1'b0;
						state  <= IDLE;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
			if (rbus.rcl) begin
				cl_hold <= 1'b1;
			end
		end
	end

	// bus line drivers, decoded from the received code
	always_comb begin
		dbus = '0;
		if (drv_en) begin
			dbus.dpa = rx_req && (rx_code == CMD_PA);
			dbus.dw  = rx_req && (rx_code == CMD_W);
			dbus.dr  = rx_req && (rx_code == CMD_R);
			dbus.din = rx_req && (rx_code == CMD_IN);
			dbus.dok = !rx_req && (rx_code == CMD_OK);
			dbus.den = !rx_req && (rx_code == CMD_EN);
			dbus.dpe = !rx_req && (rx_code == CMD_PE);
			dbus.dpn = rx_msg.a1.pn;
			dbus.dnb = rx_msg.a1.nb;
			dbus.dad = rx_msg.a2;
			dbus.ddt = rx_msg.a3;
		end
		if (state == D_EN) begin
			dbus.den = 1'b1;	// tell the bus our request collided
		end
	end

endmodule

`default_nettype wire

//--- source/iobus_pkg.sv
`default_nettype none

package iobus_pkg;

	typedef logic [0:7]  byte_t;	// one link byte
	typedef logic [0:15] word_t;	// bus address or data word
	typedef logic [0:3]  nb_t;	// block number
	typedef logic [0:3]  code_t;	// command code

	// request codes
	localparam code_t CMD_PA = 4'd0;
	localparam code_t CMD_CL = 4'd1;
	localparam code_t CMD_W  = 4'd2;
	localparam code_t CMD_R  = 4'd3;
	localparam code_t CMD_S  = 4'd4;
	localparam code_t CMD_F  = 4'd5;
	localparam code_t CMD_IN = 4'd6;

	// response codes, overlap the request codes
	localparam code_t CMD_EN = 4'd1;
	localparam code_t CMD_OK = 4'd2;
	localparam code_t CMD_PE = 4'd3;

	typedef struct packed {
		logic       req;	// set for a request
		code_t      code;
		logic [0:2] spare;	// always zero
	} msg_hdr_t;

	typedef struct packed {
		logic [0:1] spare;
		logic       qb;
		logic       pn;
		nb_t        nb;
	} msg_a1_t;

	// byte order on the link: hdr, a1, a2 hi, a2 lo, a3 hi, a3 lo
	typedef struct packed {
		msg_hdr_t hdr;
		msg_a1_t  a1;
		word_t    a2;	// address
		word_t    a3;	// data
	} msg_t;

	typedef struct packed {
		logic  rs, rf, rok, rpe, rcl, rqb, rpn;
		nb_t   rnb;
		word_t rad;
		word_t rdt;
	} rbus_t;

	typedef struct packed {
		logic  dpa, dw, dr, din, dok, den, dpe, dpn;
		nb_t   dnb;
		word_t dad;
		word_t ddt;
	} dbus_t;

	typedef enum logic [2:0] {
		IDLE, R_REQ, D_REQ, D_RESP, R_RESP, D_EN, CLEAR, WAIT
	} ctl_state_t;

endpackage

`default_nettype wire

//--- source/msg_rx.sv
`timescale 1ns/1ns
`default_nettype none

module msg_rx import iobus_pkg::*; (
	input  wire   clk_sys,
	input  wire   cl_reset,
	input  wire   byte_t rx_byte,
	input  wire   rx_strobe,
	output msg_t  rx_msg,
	output logic  msg_ready
);

	logic [2:0]  cnt;	// bytes received so far
	logic [39:0] asm_q;	// first five bytes of the message
	logic        last;

	// sixth byte completes the message
	assign last = rx_strobe && (cnt == 3'd5);

	always_ff @(posedge clk_sys or posedge cl_reset) begin
		if (cl_reset) begin
			cnt       <= 3'd0;
			msg_ready <= 1'b0;
		end else begin
			msg_ready <= last;	// one cycle pulse
			if (last) begin
				cnt <= 3'd0;	// realign for next message
			end else if (rx_strobe) begin
				cnt <= cnt + 3'd1;
			end
		end
	end

	// bytes shift in from the low end, so hdr lands on top
	always_ff @(posedge clk_sys) begin
		if (rx_strobe) begin
			asm_q <= {asm_q[31:0], rx_byte};
		end
		if (last) begin
			rx_msg <= {asm_q, rx_byte};	// held until next full message
		end
	end

endmodule

`default_nettype wire

//--- source/msg_tx.sv
`timescale 1ns/1ns
`default_nettype none

module msg_tx import iobus_pkg::*; (
	input  wire   clk_sys,
	input  wire   cl_reset,
	input  wire   tx_send,
	input  wire   msg_t tx_msg,
	input  wire   link_busy,
	output byte_t tx_byte,
	output logic  tx_strobe,
	output logic  tx_busy
);

	logic [47:0] sreg;	// outgoing bytes, next one on top
	logic [2:0]  cnt;	// bytes emitted
	logic        load;
	logic        emit;

	assign load = tx_send && !tx_busy;	// new message only when idle
	// one idle cycle between strobes, and wait out the link
	assign emit = tx_busy && !link_busy && !tx_strobe && (cnt != 3'd6);

	always_ff @(posedge clk_sys or posedge cl_reset) begin
		if (cl_reset) begin
			tx_busy   <= 1'b0;
			tx_strobe <= 1'b0;
			cnt       <= 3'd0;
		end else begin
			tx_strobe <= emit;
			if (load) begin
				tx_busy <= 1'b1;
				cnt     <= 3'd0;
			end else if (emit) begin
				cnt <= cnt + 3'd1;
			end else if (tx_strobe && (cnt == 3'd6)) begin
				tx_busy <= 1'b0;	// drops after the sixth strobe
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (load) begin
			sreg <= tx_msg;
		end else if (emit) begin
			tx_byte <= sreg[47:40];
			sreg    <= {sreg[39:0], 8'h00};
		end
	end

endmodule

`default_nettype wire

//--- tests/iobus_properties.sv
`timescale 1ns/1ns
`default_nettype none

module iobus_properties import iobus_pkg::*; (
	input wire             clk_sys,
	input wire             cl_reset,
	input wire ctl_state_t state,
	input wire             zg,
	input wire dbus_t      dbus,
	input wire             tx_send,
	input wire             tx_busy,
	input wire             msg_ready,
	input wire             rx_req
);

	int unsigned fails;	// failed assertion count
	logic        req_seen;	// request message arrived since reset

	initial fails = 0;

	always_ff @(posedge clk_sys or posedge cl_reset) begin
		if (cl_reset) begin
			req_seen <= 1'b0;
		end else if (msg_ready && rx_req) begin
			req_seen <= 1'b1;
		end
	end

	send_when_idle: assert property (@(posedge clk_sys) disable iff (cl_reset)
		tx_send |-> !tx_busy) else begin
		$error("tx_send pulsed while the transmitter was busy");
		fails++;
	end

	// only D_RESP, D_EN and a PA in WAIT drive without a grant request
	quiet_bus: assert property (@(posedge clk_sys) disable iff (cl_reset)
		(!zg && !(state inside {D_RESP, D_EN, WAIT})) |-> (dbus == '0)) else begin
		$error("d lines driven without zg in state %s", state.name());
		fails++;
	end

	no_early_grant: assert property (@(posedge clk_sys) disable iff (cl_reset)
		!req_seen |-> !zg) else begin
		$error("zg raised before any request message");
		fails++;
	end

endmodule

`default_nettype wire

//--- tests/iobus_tb.sv
`timescale 1ns/1ns
`default_nettype none

module iobus_tb import iobus_pkg::*; ();

	localparam int          N_SCEN = 15;	// scenarios run below
	localparam logic [15:0] SEED   = 16'd34218;

	typedef struct packed {
		logic  qb;
		logic  pn;
		nb_t   nb;
		word_t ad;
		word_t dt;
	} fields_t;

	logic  clk_sys, cl_reset, rx_strobe, link_busy, tx_strobe;
	byte_t rx_byte, tx_byte;
	logic  rs, rf, rok, rpe, rcl, rqb, rpn, zw;
	nb_t   rnb, dnb;
	word_t rad, rdt, dad, ddt;
	logic  zg, dpa, dw, dr, din, dok, den, dpe, dpn;

	logic [7:0]  exp_q[$];	// bytes the link should carry next
	logic [7:0]  want;
	logic [15:0] stim_seed, link_seed;
	logic [63:0] lv;
	logic [1:0]  busy_left;
	int          n_mismatch, n_fail;

	iobus u_dut (.*);

	bind iobus_ctl iobus_properties u_props (.*);

	always #5 clk_sys = ~clk_sys;

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};	// x^16+x^14+x^13+x^11+1
	endfunction

	task automatic rand_bits(inout logic [15:0] st, input int n, output logic [63:0] v);
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			st = lfsr_next(st);
			v  = {v[62:0], st[0]};
		end
	endtask

	// expected message, byte order hdr, a1, a2, a3
	function automatic logic [47:0] ref_msg(input logic req, input code_t code, input fields_t f);
		return {req, code, 3'b000, 2'b00, f.qb, f.pn, f.nb, f.ad, f.dt};
	endfunction

	// {dpa, dw, dr, din, dok, den, dpe} for a received code
	function automatic logic [6:0] strobe_of(input logic req, input code_t c);
		if (req) begin
			case (c)
				CMD_PA:  return 7'b1000000;
				CMD_W:   return 7'b0100000;
				CMD_R:   return 7'b0010000;
				CMD_IN:  return 7'b0001000;
				default: return 7'b0000000;
			endcase
		end
		case (c)
			CMD_OK:  return 7'b0000100;
			CMD_EN:  return 7'b0000010;
			CMD_PE:  return 7'b0000001;
			default: return 7'b0000000;
		endcase
	endfunction

	function automatic logic [6:0] dflags();
		return {dpa, dw, dr, din, dok, den, dpe};
	endfunction

	task automatic check_eq(input string what, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			n_mismatch++;
			$display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic next_cycle();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic expect_msg(input logic [47:0] m);
		int i;
		for (i = 0; i < 6; i++) begin
			exp_q.push_back(m[47 - 8 * i -: 8]);
		end
	endtask

	task automatic send_msg(input logic [47:0] m);
		int i;
		for (i = 0; i < 6; i++) begin
			rx_byte   = m[47 - 8 * i -: 8];
			rx_strobe = 1'b1;
			next_cycle();
			rx_strobe = 1'b0;
			next_cycle();
		end
	endtask

	// 0 zg high, 1 zg low, 2 link bytes all seen, else any strobe line
	task automatic await_cond(input int sel, input string what);
		int   n;
		logic hit;
		n   = 0;
		hit = 1'b0;
		while (!hit && n < 200) begin
			@(negedge clk_sys);
			case (sel)
				0:       hit = zg;
				1:       hit = !zg;
				2:       hit = (exp_q.size() == 0);
				default: hit = (dflags() != 7'd0);
			endcase
			n++;
		end
		if (!hit) begin
			n_fail++;
			$display("%0t: timed out waiting for %s", $time, what);
		end
	endtask

	task automatic drain();
		await_cond(2, "transmitted bytes");
		repeat (3) next_cycle();	// tx_busy falls after the last strobe
	endtask

	task automatic serve_request(input code_t code, input fields_t f, input logic ok);
		fields_t     g;
		logic [63:0] v;
		await_cond(0, "grant request zg");
		next_cycle();
		zw = 1'b1;
		await_cond(3, "request strobe");
		check_eq("request strobes", dflags(), strobe_of(1'b1, code));
		check_eq("request fields", {dpn, dnb, dad, ddt}, {f.pn, f.nb, f.ad, f.dt});
		drain();
		rand_bits(stim_seed, 38, v);
		g = v[37:0];
		{rqb, rpn, rnb, rad, rdt} = g;
		rok = ok;
		rpe = !ok;
		expect_msg(ref_msg(1'b0, ok ? CMD_OK : CMD_PE, g));
		next_cycle();
		rok = 1'b0;
		rpe = 1'b0;
		await_cond(1, "zg release");
		next_cycle();
		zw = 1'b0;
		check_eq("d lines after reply", {dflags(), dpn, dnb, dad, ddt}, '0);
		drain();
	endtask

	task automatic run_external(input code_t code, input logic ok);
		fields_t     f;
		logic [63:0] v;
		rand_bits(stim_seed, 38, v);
		f = v[37:0];
		send_msg(ref_msg(1'b1, code, f));
		serve_request(code, f, ok);
	endtask

	task automatic run_internal(input code_t resp, input logic bad_first);
		fields_t     f;
		fields_t     g;
		logic [63:0] v;
		logic        use_f;
		rand_bits(stim_seed, 39, v);
		f       = v[37:0];
		use_f   = v[38];
		f.ad[15] = 1'b0;	// inside the forwarded range
		{rqb, rpn, rnb, rad, rdt} = f;
		rs = !use_f;
		rf = use_f;
		expect_msg(ref_msg(1'b1, use_f ? CMD_F : CMD_S, f));
		rand_bits(stim_seed, 38, v);
		g = v[37:0];
		if (bad_first) begin
			send_msg(ref_msg(1'b0, CMD_IN, g));	// no response uses code 6
			check_eq("d lines after invalid response", {dflags(), dpn, dnb, dad, ddt}, '0);
		end
		send_msg(ref_msg(1'b0, resp, g));
		await_cond(3, "response strobe");
		check_eq("response strobes", dflags(), strobe_of(1'b0, resp));
		check_eq("response fields", {dpn, dnb, dad, ddt}, {g.pn, g.nb, g.ad, g.dt});
		repeat (4) next_cycle();
		check_eq("held response strobes", dflags(), strobe_of(1'b0, resp));
		rs = 1'b0;
		rf = 1'b0;
		next_cycle();
		check_eq("d lines after release", {dflags(), dpn, dnb, dad, ddt}, '0);
		drain();
	endtask

	task automatic run_blocked();
		fields_t     f;
		logic [63:0] v;
		int          i;
		rand_bits(stim_seed, 38, v);
		f       = v[37:0];
		f.ad[15] = 1'b1;	// outside the forwarded range
		{rqb, rpn, rnb, rad, rdt} = f;
		rs = 1'b1;
		for (i = 0; i < 20; i++) begin
			next_cycle();
			check_eq("zg on blocked request", zg, 1'b0);
		end
		rs = 1'b0;
		next_cycle();
	endtask

	task automatic run_pa();
		fields_t     f;
		logic [63:0] v;
		int          i;
		rand_bits(stim_seed, 38, v);
		f = v[37:0];
		send_msg(ref_msg(1'b1, CMD_PA, f));
		await_cond(3, "dpa");
		check_eq("pa strobes", dflags(), strobe_of(1'b1, CMD_PA));
		check_eq("pa fields", {dpn, dnb}, {f.pn, f.nb});
		next_cycle();
		check_eq("d lines after pa", {dflags(), dpn, dnb, dad, ddt}, '0);
		for (i = 0; i < 20; i++) begin
			next_cycle();
			check_eq("zg after pa", zg, 1'b0);
		end
	endtask

	task automatic run_clear();
		fields_t     f;
		logic [63:0] v;
		rand_bits(stim_seed, 38, v);
		f = v[37:0];
		{rqb, rpn, rnb, rad, rdt} = f;
		rcl = 1'b1;
		expect_msg(ref_msg(1'b1, CMD_CL, f));
		next_cycle();
		rcl = 1'b0;
		drain();
	endtask

	task automatic run_invalid();
		fields_t     f;
		logic [63:0] v;
		int          i;
		rand_bits(stim_seed, 38, v);
		f = v[37:0];
		send_msg(ref_msg(1'b1, CMD_CL, f));	// CL only goes outward
		for (i = 0; i < 10; i++) begin
			next_cycle();
			check_eq("bus after invalid request", {zg, dflags(), dpn, dnb, dad, ddt}, '0);
		end
		run_internal(CMD_OK, 1'b1);	// bad response while a request is open
	endtask

	task automatic run_collision();
		fields_t     f;
		fields_t     g;
		logic [63:0] v;
		rand_bits(stim_seed, 38, v);
		f       = v[37:0];
		f.ad[15] = 1'b0;
		{rqb, rpn, rnb, rad, rdt} = f;
		rs = 1'b1;
		expect_msg(ref_msg(1'b1, CMD_S, f));
		rand_bits(stim_seed, 38, v);
		g = v[37:0];
		send_msg(ref_msg(1'b1, CMD_W, g));
		check_eq("collision lines", {dflags(), dpn, dnb, dad, ddt},
			{strobe_of(1'b0, CMD_EN), 37'd0});
		check_eq("zg during collision", zg, 1'b0);
		repeat (3) next_cycle();
		check_eq("held den", dflags(), strobe_of(1'b0, CMD_EN));
		rs = 1'b0;
		serve_request(CMD_W, g, 1'b1);
	endtask

	// link model, busy for 0 to 3 cycles after each strobe
	always @(posedge clk_sys) begin
		#1;
		if (tx_strobe) begin
			rand_bits(link_seed, 2, lv);
			busy_left = lv[1:0];
			link_busy = 1'b0;
		end else if (busy_left != 2'd0) begin
			busy_left = busy_left - 2'd1;
			link_busy = 1'b1;
		end else begin
			link_busy = 1'b0;
		end
	end

	// compare every transmitted byte with the reference queue
	always @(negedge clk_sys) begin
		if (!cl_reset && tx_strobe) begin
			if (exp_q.size() == 0) begin
				n_fail++;
				$display("%0t: unexpected byte %h sent on the link", $time, tx_byte);
			end else begin
				want = exp_q.pop_front();
				if (tx_byte !== want) begin
					n_mismatch++;
					$display("MISMATCH at %0t: tx byte %h, expected %h", $time, tx_byte, want);
				end
			end
		end
	end

	initial begin
		repeat (N_SCEN * 400) @(posedge clk_sys);
		$display("timeout: run did not finish within %0d cycles", N_SCEN * 400);
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin
		int n;
		clk_sys   = 1'b0;
		cl_reset  = 1'b1;
		rx_byte   = '0;
		rx_strobe = 1'b0;
		link_busy = 1'b0;
		{rs, rf, rok, rpe, rcl, rqb, rpn, zw} = '0;
		rnb       = '0;
		rad       = '0;
		rdt       = '0;
		busy_left = 2'd0;
		stim_seed = SEED;
		link_seed = SEED;
		n_mismatch = 0;
		n_fail    = 0;
		repeat (3) @(posedge clk_sys);
		#1;
		cl_reset = 1'b0;
		next_cycle();
		for (n = 0; n < 6; n++) begin
			case (n % 3)
				0:       run_internal(CMD_OK, 1'b0);
				1:       run_internal(CMD_PE, 1'b0);
				default: run_internal(CMD_EN, 1'b0);
			endcase
		end
		run_blocked();
		run_external(CMD_W, 1'b1);
		run_external(CMD_R, 1'b0);
		run_external(CMD_IN, 1'b1);
		run_pa();
		run_clear();
		run_invalid();
		run_external(CMD_R, 1'b1);
		run_collision();
		repeat (5) next_cycle();
		if (exp_q.size() != 0) begin
			n_fail++;
			$display("%0d expected bytes were never transmitted", exp_q.size());
		end
		$display("checks done: %0d mismatches, %0d other errors, %0d assertion failures",
			n_mismatch, n_fail, u_dut.u_ctl.u_props.fails);
		if (n_mismatch == 0 && n_fail == 0 && u_dut.u_ctl.u_props.fails == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire
